//--- design/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

	//////////////////////////////////////////////////
	// core sizes
	//////////////////////////////////////////////////
	localparam int xlen       = 16; // data path width
	localparam int arch_regs  = 8;
	localparam int arch_idx_w = 3;
	localparam int phys_regs  = 16; // 0..7 mapped at reset, 8..15 free
	localparam int phys_idx_w = 4;
	localparam int rob_depth  = 8;
	localparam int rob_idx_w  = 3;
	localparam int rs_depth   = 4;
	localparam int mul_stages = 3;  // multiplier latency in cycles

	// decoded operation, as presented at the core input
	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_XOR,
		OP_ADDI,  // second operand is the immediate
		OP_MUL,   // low half of the product only
		OP_HALT
	} opcode_e;

	typedef enum logic [1:0] {
		ST_RUN,    // accepting instructions
		ST_DRAIN,  // halt dispatched, waiting for it at the rob head
		ST_HALTED
	} core_state_e;

	// rs -> function unit, 43 bits
	typedef struct packed {
		logic                  valid;
		opcode_e               op;
		logic [xlen-1:0]       opa;
		logic [xlen-1:0]       opb;
		logic [phys_idx_w-1:0] pdst;
		logic [rob_idx_w-1:0]  rob_idx;
	} issue_t;

endpackage

`default_nettype wire

//--- design/core_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// result broadcast, one cycle per valid, no acknowledge
interface cdb_if;
	logic                            valid;
	logic [ooo_pkg::phys_idx_w-1:0]  tag;     // physical dest register
	logic [ooo_pkg::xlen-1:0]        value;
	logic [ooo_pkg::rob_idx_w-1:0]   rob_idx; // rob entry to mark done

	modport producer (output valid, tag, value, rob_idx);
	modport consumer (input valid, tag, value, rob_idx);
endinterface

// one instruction moves into rat, rs and rob when strobe is high
interface dispatch_if;
	logic                            strobe;
	logic [ooo_pkg::arch_idx_w-1:0]  rd;
	logic [ooo_pkg::phys_idx_w-1:0]  pdst;     // newly allocated register
	logic [ooo_pkg::phys_idx_w-1:0]  old_pdst; // previous mapping of rd
	logic [ooo_pkg::rob_idx_w-1:0]   rob_idx;  // rob tail
	logic                            is_halt;

	modport ctrl     (output strobe, is_halt);
	modport rat_sink (input strobe, rd, output pdst, old_pdst);
	modport rob_sink (input strobe, rd, pdst, old_pdst, is_halt, output rob_idx);
	modport sink     (input strobe, pdst, rob_idx);
endinterface

`default_nettype wire

//--- design/dispatch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_ctrl (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire                   inst_valid,
	input  wire ooo_pkg::opcode_e inst_op,
	input  wire                   rob_full,
	input  wire                   rs_full,
	input  wire                   free_empty,
	input  wire                   halt_commit,   // halt entry left the rob head
	output logic                  stall,
	output logic                  halted,
	dispatch_if.ctrl              dispatch,
	output logic                  alloc,         // instruction needs a dest register
	output logic                  rs_load        // instruction needs a station entry
);

	ooo_pkg::core_state_e state, state_nxt;
	logic                 is_halt;

	assign is_halt = (inst_op == ooo_pkg::OP_HALT);
	assign alloc   = !is_halt;  // halt writes no register
	assign rs_load = !is_halt;  // and never executes

	// stall is a level, independent of inst_valid
	always_comb begin
		stall = (state != ooo_pkg::ST_RUN) || rob_full;
		if (rs_load && rs_full)
			stall = 1'b1;
		if (alloc && free_empty)
			stall = 1'b1;  // no physical register left
	end

	assign dispatch.strobe  = inst_valid && !stall;
	assign dispatch.is_halt = is_halt;
	assign halted           = (state == ooo_pkg::ST_HALTED);

	always_comb begin
		state_nxt = state;
		case (state)
			ooo_pkg::ST_RUN:
				if (dispatch.strobe && is_halt)
					state_nxt = ooo_pkg::ST_DRAIN;
			ooo_pkg::ST_DRAIN:
				if (halt_commit)
					state_nxt = ooo_pkg::ST_HALTED;  // all older work committed
			default:
				state_nxt = state;  // stays halted until reset
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			state <= ooo_pkg::ST_RUN;
		else
			state <= state_nxt;
	end

endmodule

`default_nettype wire

//--- design/rename_table.sv
`timescale 1ns/1ps
`default_nettype none

module rename_table (
	input  wire                               clk,
	input  wire                               arst_n,
	input  wire [ooo_pkg::arch_idx_w-1:0]     inst_rs1,
	input  wire [ooo_pkg::arch_idx_w-1:0]     inst_rs2,
	input  wire                               alloc,
	dispatch_if.rat_sink                      dispatch,
	input  wire                               free_valid,  // commit returns a register
	input  wire [ooo_pkg::phys_idx_w-1:0]     free_idx,
	output logic [ooo_pkg::phys_idx_w-1:0]    src1_p,
	output logic [ooo_pkg::phys_idx_w-1:0]    src2_p,
	output logic                              free_empty
);

	logic [ooo_pkg::phys_idx_w-1:0] map [ooo_pkg::arch_regs];  // arch -> phys
	logic [ooo_pkg::phys_regs-1:0]  free_mask;                 // 1 = free
	logic [ooo_pkg::phys_idx_w-1:0] first_free;

	// lowest free register wins
	always_comb begin
		first_free = '0;
		for (int i = ooo_pkg::phys_regs - 1; i >= 0; i--)
			if (free_mask[i])
				first_free = i[ooo_pkg::phys_idx_w-1:0];
	end

	assign free_empty        = ~|free_mask;
	assign src1_p            = map[inst_rs1];  // read before this dispatch renames rd
	assign src2_p            = map[inst_rs2];
	assign dispatch.pdst     = first_free;
	assign dispatch.old_pdst = map[dispatch.rd];  // freed when this instruction commits

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < ooo_pkg::arch_regs; i++)
				map[i] <= i[ooo_pkg::phys_idx_w-1:0];  // identity mapping
			free_mask <= {{(ooo_pkg::phys_regs - ooo_pkg::arch_regs){1'b1}},
				{ooo_pkg::arch_regs{1'b0}}};
		end else begin
			if (dispatch.strobe && alloc) begin
				map[dispatch.rd]      <= first_free;
				free_mask[first_free] <= 1'b0;
			end
			// never the register taken above, that one was free
			if (free_valid)
				free_mask[free_idx] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- design/phys_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module phys_regfile (
	input  wire                           clk,
	input  wire                           arst_n,
	input  wire [ooo_pkg::phys_idx_w-1:0] src1_p,
	input  wire [ooo_pkg::phys_idx_w-1:0] src2_p,
	input  wire [ooo_pkg::phys_idx_w-1:0] alloc_p,   // new pdst
	input  wire                           alloc,     // dispatch takes alloc_p
	cdb_if.consumer                       cdb,
	input  wire [ooo_pkg::phys_idx_w-1:0] commit_p,  // pdst at the rob head
	output logic [ooo_pkg::xlen-1:0]      src1_val,
	output logic [ooo_pkg::xlen-1:0]      src2_val,
	output logic                          src1_rdy,
	output logic                          src2_rdy,
	output logic [ooo_pkg::xlen-1:0]      commit_val
);

	logic [ooo_pkg::xlen-1:0]      vals [ooo_pkg::phys_regs];
	logic [ooo_pkg::phys_regs-1:0] rdy;
	logic                          hit1, hit2;

	// same-cycle broadcast beats the array
	assign hit1     = cdb.valid && (cdb.tag == src1_p);
	assign hit2     = cdb.valid && (cdb.tag == src2_p);
	assign src1_rdy = rdy[src1_p] || hit1;
	assign src2_rdy = rdy[src2_p] || hit2;
	assign src1_val = hit1 ? cdb.value : vals[src1_p];
	assign src2_val = hit2 ? cdb.value : vals[src2_p];

	assign commit_val = vals[commit_p];  // written on the edge that marked it done

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < ooo_pkg::phys_regs; i++)
				vals[i] <= '0;  // architectural state starts at zero
			rdy <= '1;
		end else begin
			if (alloc)
				rdy[alloc_p] <= 1'b0;  // value still in flight
			if (cdb.valid) begin
				vals[cdb.tag] <= cdb.value;
				rdy[cdb.tag]  <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station (
	input  wire                           clk,
	input  wire                           arst_n,
	dispatch_if.sink                      dispatch,
	input  wire                           rs_load,
	input  wire ooo_pkg::opcode_e         inst_op,
	input  wire [ooo_pkg::xlen-1:0]       inst_imm,
	input  wire [ooo_pkg::phys_idx_w-1:0] src1_p,
	input  wire [ooo_pkg::phys_idx_w-1:0] src2_p,
	input  wire [ooo_pkg::xlen-1:0]       src1_val,
	input  wire [ooo_pkg::xlen-1:0]       src2_val,
	input  wire                           src1_rdy,
	input  wire                           src2_rdy,
	cdb_if.consumer                       cdb,
	input  wire                           alu_busy,   // alu result held off the bus
	output ooo_pkg::issue_t               alu_issue,
	output ooo_pkg::issue_t               mul_issue,
	output logic                          rs_full
);

	ooo_pkg::opcode_e               op    [ooo_pkg::rs_depth];
	logic [ooo_pkg::xlen-1:0]       opa   [ooo_pkg::rs_depth];
	logic [ooo_pkg::xlen-1:0]       opb   [ooo_pkg::rs_depth];
	logic [ooo_pkg::phys_idx_w-1:0] tag_a [ooo_pkg::rs_depth];
	logic [ooo_pkg::phys_idx_w-1:0] tag_b [ooo_pkg::rs_depth];
	logic [ooo_pkg::phys_idx_w-1:0] pdst  [ooo_pkg::rs_depth];
	logic [ooo_pkg::rob_idx_w-1:0]  rob   [ooo_pkg::rs_depth];
	logic [ooo_pkg::rs_depth-1:0]   older [ooo_pkg::rs_depth];  // older[i][j]: i before j
	logic [ooo_pkg::rs_depth-1:0]   valid, rdy_a, rdy_b;
	logic [ooo_pkg::rs_depth-1:0]   mul_rdy, alu_rdy, mul_pick, alu_pick;
	logic [ooo_pkg::rs_depth-1:0]   load_sel;  // one-hot free slot
	logic                           load;

	assign load     = dispatch.strobe && rs_load;
	assign rs_full  = &valid;
	assign load_sel = ~valid & (valid + 1'b1);  // lowest empty entry

	//////////////////////////////////////////////////
	// select the oldest ready entry per unit
	//////////////////////////////////////////////////
	always_comb begin
		for (int i = 0; i < ooo_pkg::rs_depth; i++) begin
			mul_rdy[i] = valid[i] && rdy_a[i] && rdy_b[i] && (op[i] == ooo_pkg::OP_MUL);
			alu_rdy[i] = valid[i] && rdy_a[i] && rdy_b[i] && (op[i] != ooo_pkg::OP_MUL)
				&& !alu_busy;
		end
		for (int i = 0; i < ooo_pkg::rs_depth; i++) begin
			mul_pick[i] = mul_rdy[i];
			alu_pick[i] = alu_rdy[i];
			for (int j = 0; j < ooo_pkg::rs_depth; j++) begin
				if (older[j][i] && mul_rdy[j])
					mul_pick[i] = 1'b0;  // an older multiply goes first
				if (older[j][i] && alu_rdy[j])
					alu_pick[i] = 1'b0;
			end
		end
	end

	always_comb begin
		alu_issue = '0;
		mul_issue = '0;
		for (int i = 0; i < ooo_pkg::rs_depth; i++) begin
			if (alu_pick[i])
				alu_issue = '{1'b1, op[i], opa[i], opb[i], pdst[i], rob[i]};
			if (mul_pick[i])
				mul_issue = '{1'b1, op[i], opa[i], opb[i], pdst[i], rob[i]};
		end
	end

	// occupancy and age order
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid <= '0;
			for (int i = 0; i < ooo_pkg::rs_depth; i++)
				older[i] <= '0;
		end else begin
			for (int i = 0; i < ooo_pkg::rs_depth; i++) begin
				if (alu_pick[i] || mul_pick[i])
					valid[i] <= 1'b0;
				if (load && load_sel[i]) begin
					valid[i] <= 1'b1;
					older[i] <= '0;  // newest, older than nobody
				end else if (load) begin
					older[i] <= (older[i] & ~load_sel) | (load_sel & {ooo_pkg::rs_depth{valid[i]}});
				end
			end
		end
	end

	// operands, tags and wakeup
	always_ff @(posedge clk) begin
		for (int i = 0; i < ooo_pkg::rs_depth; i++) begin
			if (load && load_sel[i]) begin
				op[i]    <= inst_op;
				opa[i]   <= src1_val;
				rdy_a[i] <= src1_rdy;
				tag_a[i] <= src1_p;
				opb[i]   <= (inst_op == ooo_pkg::OP_ADDI) ? inst_imm : src2_val;
				rdy_b[i] <= (inst_op == ooo_pkg::OP_ADDI) || src2_rdy;
				tag_b[i] <= src2_p;
				pdst[i]  <= dispatch.pdst;
				rob[i]   <= dispatch.rob_idx;
			end else begin
				if (cdb.valid && !rdy_a[i] && (cdb.tag == tag_a[i])) begin
					opa[i]   <= cdb.value;  // capture broadcast
					rdy_a[i] <= 1'b1;
				end
				if (cdb.valid && !rdy_b[i] && (cdb.tag == tag_b[i])) begin
					opb[i]   <= cdb.value;
					rdy_b[i] <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- design/exec_units.sv
`timescale 1ns/1ps
`default_nettype none

module exec_units (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire ooo_pkg::issue_t  alu_issue,
	input  wire ooo_pkg::issue_t  mul_issue,
	output logic                  alu_busy,   // held alu result blocks a new issue
	cdb_if.producer               cdb
);

	logic                           alu_v;
	logic [ooo_pkg::xlen-1:0]       alu_res, alu_val;
	logic [ooo_pkg::phys_idx_w-1:0] alu_tag;
	logic [ooo_pkg::rob_idx_w-1:0]  alu_rob;
	logic [ooo_pkg::mul_stages-1:0] mul_v;
	logic [ooo_pkg::xlen-1:0]       mul_val [ooo_pkg::mul_stages];
	logic [ooo_pkg::phys_idx_w-1:0] mul_tag [ooo_pkg::mul_stages];
	logic [ooo_pkg::rob_idx_w-1:0]  mul_rob [ooo_pkg::mul_stages];

	// multiplier owns the bus this cycle
	assign alu_busy = alu_v && mul_v[ooo_pkg::mul_stages-1];

	always_comb begin
		case (alu_issue.op)
			ooo_pkg::OP_SUB: alu_res = alu_issue.opa - alu_issue.opb;
			ooo_pkg::OP_AND: alu_res = alu_issue.opa & alu_issue.opb;
			ooo_pkg::OP_XOR: alu_res = alu_issue.opa ^ alu_issue.opb;
			default:         alu_res = alu_issue.opa + alu_issue.opb;  // add, addi
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			alu_v <= 1'b0;
			mul_v <= '0;
		end else begin
			if (!alu_busy)
				alu_v <= alu_issue.valid;
			mul_v <= {mul_v[ooo_pkg::mul_stages-2:0], mul_issue.valid};  // never stalls
		end
	end

	always_ff @(posedge clk) begin
		if (!alu_busy) begin
			alu_val <= alu_res;
			alu_tag <= alu_issue.pdst;
			alu_rob <= alu_issue.rob_idx;
		end
		mul_val[0] <= mul_issue.opa * mul_issue.opb;  // low 16 bits
		mul_tag[0] <= mul_issue.pdst;
		mul_rob[0] <= mul_issue.rob_idx;
		for (int s = 1; s < ooo_pkg::mul_stages; s++) begin
			mul_val[s] <= mul_val[s-1];
			mul_tag[s] <= mul_tag[s-1];
			mul_rob[s] <= mul_rob[s-1];
		end
	end

	//////////////////////////////////////////////////
	// cdb grant, multiplier first
	//////////////////////////////////////////////////
	assign cdb.valid   = mul_v[ooo_pkg::mul_stages-1] || alu_v;
	assign cdb.tag     = mul_v[ooo_pkg::mul_stages-1] ? mul_tag[ooo_pkg::mul_stages-1] : alu_tag;
	assign cdb.value   = mul_v[ooo_pkg::mul_stages-1] ? mul_val[ooo_pkg::mul_stages-1] : alu_val;
	assign cdb.rob_idx = mul_v[ooo_pkg::mul_stages-1] ? mul_rob[ooo_pkg::mul_stages-1] : alu_rob;

endmodule

`default_nettype wire

//--- design/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
	input  wire                            clk,
	input  wire                            arst_n,
	dispatch_if.rob_sink                   dispatch,
	cdb_if.consumer                        cdb,
	input  wire [ooo_pkg::xlen-1:0]        commit_val,   // prf value at commit_p
	output logic                           rob_full,
	output logic                           commit_valid,
	output logic [ooo_pkg::arch_idx_w-1:0] commit_rd,
	output logic [ooo_pkg::xlen-1:0]       commit_value,
	output logic [ooo_pkg::phys_idx_w-1:0] commit_p,
	output logic                           free_valid,
	output logic [ooo_pkg::phys_idx_w-1:0] free_idx,
	output logic                           halt_commit
);

	logic [ooo_pkg::arch_idx_w-1:0] rd       [ooo_pkg::rob_depth];
	logic [ooo_pkg::phys_idx_w-1:0] pdst     [ooo_pkg::rob_depth];
	logic [ooo_pkg::phys_idx_w-1:0] old_pdst [ooo_pkg::rob_depth];
	logic [ooo_pkg::rob_depth-1:0]  halt, done;
	logic [ooo_pkg::rob_idx_w-1:0]  head, tail;
	logic [ooo_pkg::rob_idx_w:0]    count;
	logic                           retire;

	assign rob_full         = (count == ooo_pkg::rob_depth);
	assign dispatch.rob_idx = tail;

	// head leaves one cycle after its done bit is set
	assign retire       = (count != '0) && done[head];
	assign commit_valid = retire && !halt[head];
	assign halt_commit  = retire && halt[head];  // halt reports here, not on commit
	assign commit_rd    = rd[head];
	assign commit_p     = pdst[head];
	assign commit_value = commit_val;
	assign free_valid   = commit_valid;
	assign free_idx     = old_pdst[head];  // previous mapping is dead now

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
			done  <= '0;
		end else begin
			if (dispatch.strobe) begin
				done[tail] <= dispatch.is_halt;  // halt has nothing to wait for
				tail       <= tail + 1'b1;
			end
			if (cdb.valid)
				done[cdb.rob_idx] <= 1'b1;
			if (retire)
				head <= head + 1'b1;
			count <= count + dispatch.strobe - retire;
		end
	end

	always_ff @(posedge clk) begin
		if (dispatch.strobe) begin
			rd[tail]       <= dispatch.rd;
			pdst[tail]     <= dispatch.pdst;
			old_pdst[tail] <= dispatch.old_pdst;
			halt[tail]     <= dispatch.is_halt;
		end
	end

endmodule

`default_nettype wire

//--- design/ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core (
	input  wire                            clk,
	input  wire                            arst_n,
	input  wire                            inst_valid,
	input  wire ooo_pkg::opcode_e          inst_op,
	input  wire [ooo_pkg::arch_idx_w-1:0]  inst_rd,
	input  wire [ooo_pkg::arch_idx_w-1:0]  inst_rs1,
	input  wire [ooo_pkg::arch_idx_w-1:0]  inst_rs2,
	input  wire [ooo_pkg::xlen-1:0]        inst_imm,
	output logic                           stall,
	output logic                           halted,
	output logic                           commit_valid,
	output logic [ooo_pkg::arch_idx_w-1:0] commit_rd,
	output logic [ooo_pkg::xlen-1:0]       commit_value
);

	logic                           rob_full, rs_full, free_empty, halt_commit;
	logic                           alloc, rs_load, alloc_en, alu_busy;
	logic [ooo_pkg::phys_idx_w-1:0] src1_p, src2_p, commit_p, free_idx;
	logic [ooo_pkg::xlen-1:0]       src1_val, src2_val, commit_val;
	logic                           src1_rdy, src2_rdy, free_valid;
	ooo_pkg::issue_t                alu_issue, mul_issue;

	cdb_if      cdb ();
	dispatch_if dsp ();

	assign dsp.rd   = inst_rd;
	assign alloc_en = dsp.strobe && alloc;  // prf clears ready only on a real dispatch

	dispatch_ctrl i_dispatch_ctrl (
		.clk, .arst_n, .inst_valid, .inst_op, .rob_full, .rs_full, .free_empty,
		.halt_commit, .stall, .halted, .dispatch(dsp), .alloc, .rs_load
	);

	rename_table i_rename_table (
		.clk, .arst_n, .inst_rs1, .inst_rs2, .alloc, .dispatch(dsp),
		.free_valid, .free_idx, .src1_p, .src2_p, .free_empty
	);

	phys_regfile i_phys_regfile (
		.clk, .arst_n, .src1_p, .src2_p, .alloc_p(dsp.pdst), .alloc(alloc_en),
		.cdb, .commit_p, .src1_val, .src2_val, .src1_rdy, .src2_rdy, .commit_val
	);

	reservation_station i_reservation_station (
		.clk, .arst_n, .dispatch(dsp), .rs_load, .inst_op, .inst_imm,
		.src1_p, .src2_p, .src1_val, .src2_val, .src1_rdy, .src2_rdy,
		.cdb, .alu_busy, .alu_issue, .mul_issue, .rs_full
	);

	exec_units i_exec_units (
		.clk, .arst_n, .alu_issue, .mul_issue, .alu_busy, .cdb
	);

	reorder_buffer i_reorder_buffer (
		.clk, .arst_n, .dispatch(dsp), .cdb, .commit_val, .rob_full,
		.commit_valid, .commit_rd, .commit_value, .commit_p,
		.free_valid, .free_idx, .halt_commit
	);

endmodule

`default_nettype wire

//--- tests/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;  // 8 ns period
	end

	// reset held low for 8 rising edges
	initial begin
		arst_n = 1'b0;
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

`default_nettype wire

//--- tests/ooo_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core_properties (
	input wire clk,
	input wire arst_n,
	input wire commit_valid,
	input wire halted,
	input wire stall
);

	// a halted core retires nothing
	no_commit_when_halted: assert property (@(posedge clk) disable iff (!arst_n)
		halted |-> !commit_valid) else $error("commit_valid high while halted");

	stall_when_halted: assert property (@(posedge clk) disable iff (!arst_n)
		halted |-> stall) else $error("stall low while halted");

	// only reset leaves the halted state
	halted_is_sticky: assert property (@(posedge clk) disable iff (!arst_n)
		halted |=> halted) else $error("halted dropped without reset");

	no_commit_after_reset: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(arst_n) |-> !commit_valid) else $error("commit_valid right after reset");

endmodule

bind ooo_core ooo_core_properties i_ooo_core_properties (
	.clk(clk), .arst_n(arst_n), .commit_valid(commit_valid), .halted(halted), .stall(stall)
);

`default_nettype wire

//--- tests/tb_ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core;

	logic                           clk, arst_n;
	logic                           inst_valid;
	ooo_pkg::opcode_e               inst_op;
	logic [ooo_pkg::arch_idx_w-1:0] inst_rd, inst_rs1, inst_rs2;
	logic [ooo_pkg::xlen-1:0]       inst_imm;
	logic                           stall, halted, commit_valid;
	logic [ooo_pkg::arch_idx_w-1:0] commit_rd;
	logic [ooo_pkg::xlen-1:0]       commit_value;

	// program table, one row per instruction
	string                          tbl_name [$];
	ooo_pkg::opcode_e               tbl_op   [$];
	logic [ooo_pkg::arch_idx_w-1:0] tbl_rd [$], tbl_rs1 [$], tbl_rs2 [$];
	logic [ooo_pkg::xlen-1:0]       tbl_imm  [$];
	// expected commits in program order, halts left out
	string                          exp_name [$];
	logic [ooo_pkg::arch_idx_w-1:0] exp_rd   [$];
	logic [ooo_pkg::xlen-1:0]       exp_val  [$];
	logic [ooo_pkg::xlen-1:0]       model_regs [ooo_pkg::arch_regs];  // architectural model

	int value_errs, other_errs, commits, n_expected, cycles, timeout_limit;
	logic bp_stall_seen;
	string cur_name;
	logic [ooo_pkg::arch_idx_w-1:0] cur_rd;
	logic [ooo_pkg::xlen-1:0] cur_val;

	clk_gen i_clk_gen (.clk, .arst_n);

	ooo_core i_ooo_core (
		.clk, .arst_n, .inst_valid, .inst_op, .inst_rd, .inst_rs1, .inst_rs2, .inst_imm,
		.stall, .halted, .commit_valid, .commit_rd, .commit_value
	);

	//////////////////////////////////////////////////
	// reference model and table building
	//////////////////////////////////////////////////
	function automatic logic [ooo_pkg::xlen-1:0] model_result(input ooo_pkg::opcode_e op,
		input logic [ooo_pkg::xlen-1:0] a, input logic [ooo_pkg::xlen-1:0] b,
		input logic [ooo_pkg::xlen-1:0] imm);
		logic [2*ooo_pkg::xlen-1:0] prod;
		prod = a * b;
		case (op)
			ooo_pkg::OP_ADD:  return a + b;
			ooo_pkg::OP_SUB:  return a - b;
			ooo_pkg::OP_AND:  return a & b;
			ooo_pkg::OP_XOR:  return a ^ b;
			ooo_pkg::OP_ADDI: return a + imm;
			ooo_pkg::OP_MUL:  return prod[ooo_pkg::xlen-1:0];  // low half kept
			default:          return '0;                       // halt writes nothing
		endcase
	endfunction

	task automatic add_row(input string name, input ooo_pkg::opcode_e op, input int rd,
		input int rs1, input int rs2, input logic [ooo_pkg::xlen-1:0] imm);
		logic [ooo_pkg::xlen-1:0] res;
		res = model_result(op, model_regs[rs1], model_regs[rs2], imm);
		tbl_name.push_back(name);
		tbl_op.push_back(op);
		tbl_rd.push_back(rd[ooo_pkg::arch_idx_w-1:0]);
		tbl_rs1.push_back(rs1[ooo_pkg::arch_idx_w-1:0]);
		tbl_rs2.push_back(rs2[ooo_pkg::arch_idx_w-1:0]);
		tbl_imm.push_back(imm);
		if (op != ooo_pkg::OP_HALT) begin
			model_regs[rd] = res;  // program order update
			exp_name.push_back(name);
			exp_rd.push_back(rd[ooo_pkg::arch_idx_w-1:0]);
			exp_val.push_back(res);
		end
	endtask

	task automatic check_val(input string name, input int expected, input int actual);
		assert (expected == actual) else begin
			value_errs++;
			$display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	// presents one row from a rising edge and returns on the edge that takes it
	task automatic send_row(input int i);
		logic taken;
		inst_valid <= 1'b1;
		inst_op    <= tbl_op[i];
		inst_rd    <= tbl_rd[i];
		inst_rs1   <= tbl_rs1[i];
		inst_rs2   <= tbl_rs2[i];
		inst_imm   <= tbl_imm[i];
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = !stall;
			if (stall && tbl_name[i] == "backpressure")
				bp_stall_seen = 1'b1;
			@(posedge clk);
		end
	endtask

	//////////////////////////////////////////////////
	// commit monitor and timeout
	//////////////////////////////////////////////////
	always @(negedge clk) begin
		if (arst_n && commit_valid) begin
			commits++;
			assert (exp_val.size() > 0) else begin
				other_errs++;
				$display("commit of r%0d arrived with no instruction left to commit", commit_rd);
			end
			if (exp_val.size() > 0) begin
				cur_name = exp_name.pop_front();
				cur_rd   = exp_rd.pop_front();
				cur_val  = exp_val.pop_front();
				assert (commit_rd == cur_rd && commit_value == cur_val) else begin
					value_errs++;
					$display("[FAIL] %s: expected r%0d=%h, actual r%0d=%h",
						cur_name, cur_rd, cur_val, commit_rd, commit_value);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= timeout_limit) begin
			$display("timeout: run did not finish within %0d cycles", timeout_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		inst_valid = 1'b0;
		inst_op = ooo_pkg::OP_ADD;
		inst_rd = '0;
		inst_rs1 = '0;
		inst_rs2 = '0;
		inst_imm = '0;
		value_errs = 0;
		other_errs = 0;
		commits = 0;
		cycles = 0;
		bp_stall_seen = 1'b0;
		for (int r = 0; r < ooo_pkg::arch_regs; r++)
			model_regs[r] = '0;
		// independent alu work
		add_row("alu", ooo_pkg::OP_ADDI, 1, 0, 0, 16'h0005);
		add_row("alu", ooo_pkg::OP_ADDI, 2, 0, 0, 16'h1234);
		add_row("alu", ooo_pkg::OP_ADDI, 3, 0, 0, 16'h00f0);
		add_row("alu", ooo_pkg::OP_ADDI, 4, 0, 0, 16'hfff0);
		add_row("alu", ooo_pkg::OP_ADD, 5, 1, 2, 16'h0);
		add_row("alu", ooo_pkg::OP_SUB, 6, 1, 2, 16'h0);
		add_row("alu", ooo_pkg::OP_AND, 7, 2, 3, 16'h0);
		add_row("alu", ooo_pkg::OP_XOR, 4, 4, 2, 16'h0);
		// multiply feeding dependents, one independent addi overtakes it
		add_row("wakeup", ooo_pkg::OP_MUL, 1, 2, 3, 16'h0);
		add_row("wakeup", ooo_pkg::OP_ADD, 5, 1, 3, 16'h0);
		add_row("wakeup", ooo_pkg::OP_ADDI, 6, 0, 0, 16'h0042);
		add_row("wakeup", ooo_pkg::OP_XOR, 7, 5, 1, 16'h0);
		add_row("wakeup", ooo_pkg::OP_ADDI, 2, 1, 0, 16'h0003);
		// serial chain, odd immediates keep the product from reaching zero
		for (int k = 0; k < 6; k++) begin
			add_row("backpressure", ooo_pkg::OP_MUL, 4, 3, 6, 16'h0);
			add_row("backpressure", ooo_pkg::OP_ADDI, 3, 4, 0, 16'h0101 + 16'(2 * k));
		end
		add_row("halt", ooo_pkg::OP_HALT, 0, 0, 0, 16'h0);
		n_expected = exp_val.size();
		timeout_limit = 8 + 20 * tbl_op.size() + 100;

		wait (arst_n === 1'b1);
		@(negedge clk);
		check_val("reset commit_valid", 0, commit_valid);
		check_val("reset halted", 0, halted);
		check_val("reset stall", 0, stall);

		@(posedge clk);
		for (int i = 0; i < tbl_op.size(); i++)
			send_row(i);
		// one more instruction behind the halt, never to be taken
		inst_op  <= ooo_pkg::OP_ADDI;
		inst_rd  <= 3'd1;
		inst_imm <= 16'h0055;

		do @(negedge clk); while (!halted);
		check_val("halt commits before halted", n_expected, commits);
		check_val("halt pending commits", 0, exp_val.size());
		assert (bp_stall_seen) else begin
			other_errs++;
			$display("stall never rose during the back-pressure run");
		end
		repeat (20) begin
			@(negedge clk);
			check_val("halt stall", 1, stall);
			check_val("halt halted", 1, halted);
		end
		check_val("halt no later commits", n_expected, commits);

		$display("%0d commits checked, %0d value errors, %0d other errors",
			commits, value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- ooo_core.f
design/ooo_pkg.sv
design/core_ifs.sv
design/dispatch_ctrl.sv
design/rename_table.sv
design/phys_regfile.sv
design/reservation_station.sv
design/exec_units.sv
design/reorder_buffer.sv
design/ooo_core.sv
tests/clk_gen.sv
tests/ooo_core_properties.sv
tests/tb_ooo_core.sv
